/* build.f */
+incdir+dv
rtl/ipic_pkg.sv
rtl/ipic_cfg_if.sv
rtl/ipic_line_detect.sv
rtl/ipic_pending.sv
rtl/ipic_service.sv
rtl/ipic_regs.sv
rtl/ipic_top.sv
dv/tb_ipic.sv

/* dv/tb_ipic_tests.svh */
// Directed IPIC tests with a small reference model of the pending and priority rules
`ifndef TB_IPIC_TESTS_SVH
`define TB_IPIC_TESTS_SVH

// ------------------------------
// Reference model
// ------------------------------
// Lowest set line wins and 16 means none
function automatic int lowest_line(input logic [15:0] v);
    int  res;
    bit  found;
    res   = 16;
    found = 1'b0;
    for (int i = 0; i < 16; i++) begin
        if (v[i] && !found) begin
            res   = i;
            found = 1'b1;
        end
    end
    return res;
endfunction

// ICSR word with IP 0, IE 1, IM 2, INV 3, IS 4, PRV 9:8 and line 19:16
function automatic logic [31:0] icsr_word(input logic ip, input logic ie, input logic im,
                                          input logic inv, input logic insv,
                                          input logic [3:0] line);
    logic [31:0] w;
    w        = '0;
    w[0]     = ip;
    w[1]     = ie;
    w[2]     = im;
    w[3]     = inv;
    w[4]     = insv;
    w[9:8]   = 2'd3;
    w[19:16] = line;
    return w;
endfunction

// Select a line and write its enable, mode and inversion
task automatic setup_line(input logic [3:0] idx, input logic ie, input logic im,
                          input logic inv);
    bus_write(ADDR_IDX, {28'd0, idx});
    bus_write(ADDR_ICSR, icsr_word(1'b0, ie, im, inv, 1'b0, 4'd0));
endtask

// ------------------------------
// Tests
// ------------------------------
task automatic test_reset();
    logic [31:0] rd;
    bus_read(ADDR_CISV, rd);
    check_value("reset CISV", 32'd16, rd);
    bus_read(ADDR_IPR, rd);
    check_value("reset IPR", 32'd0, rd);
    bus_read(ADDR_ISVR, rd);
    check_value("reset ISVR", 32'd0, rd);
    bus_read(ADDR_IDX, rd);
    check_value("reset IDX", 32'd0, rd);
    check_req("reset request", 1'b0);
endtask

task automatic test_level();
    logic [31:0] rd;
    setup_line(4'd5, 1'b1, 1'b0, 1'b0);
    drive_lines(16'h0020);
    wait_lines();
    bus_read(ADDR_IPR, rd);
    check_value("level IPR after raise", 32'h0000_0020, rd);
    check_req("level request after raise", 1'b1);
    drive_lines(16'h0000);
    wait_lines();
    bus_read(ADDR_IPR, rd);
    check_value("level IPR after drop", 32'd0, rd);
    check_req("level request after drop", 1'b0);
    // Inverted line is active while low
    bus_write(ADDR_ICSR, icsr_word(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 4'd0));
    wait_lines();
    bus_read(ADDR_IPR, rd);
    check_value("inverted IPR", 32'h0000_0020, rd);
    bus_read(ADDR_ICSR, rd);
    check_value("ICSR fields", icsr_word(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 4'd5), rd);
    bus_write(ADDR_ICSR, 32'd0);
endtask

task automatic test_edge();
    logic [31:0] rd;
    setup_line(4'd7, 1'b1, 1'b1, 1'b0);
    // One-cycle pulse
    drive_lines(16'h0080);
    drive_lines(16'h0000);
    wait_lines();
    wait_lines();
    bus_read(ADDR_IPR, rd);
    check_value("edge IPR held", 32'h0000_0080, rd);
    bus_write(ADDR_IPR, 32'h0000_0080);
    bus_read(ADDR_IPR, rd);
    check_value("edge IPR cleared", 32'd0, rd);
    // Active level line ignores the clear
    setup_line(4'd2, 1'b1, 1'b0, 1'b0);
    drive_lines(16'h0004);
    wait_lines();
    bus_write(ADDR_IPR, 32'h0000_0004);
    // Request seen in the cycle right after the write edge
    check_req("level request kept on clear", 1'b1);
    bus_read(ADDR_IPR, rd);
    check_value("level IPR kept on clear", 32'h0000_0004, rd);
    drive_lines(16'h0000);
    bus_write(ADDR_ICSR, 32'd0);
    setup_line(4'd7, 1'b0, 1'b0, 1'b0);
    wait_lines();
endtask

task automatic test_nesting();
    logic [31:0] rd;
    setup_line(4'd9, 1'b1, 1'b0, 1'b0);
    setup_line(4'd3, 1'b1, 1'b0, 1'b0);
    drive_lines(16'h0200);
    wait_lines();
    bus_write(ADDR_SOI, 32'd0);
    bus_read(ADDR_CISV, rd);
    check_value("nest CISV first", 32'd9, rd);
    check_req("nest request in service", 1'b0);
    // Higher priority line preempts
    drive_lines(16'h0208);
    wait_lines();
    check_req("nest request preempt", 1'b1);
    bus_write(ADDR_SOI, 32'd0);
    bus_read(ADDR_CISV, rd);
    check_value("nest CISV second", 32'd3, rd);
    bus_read(ADDR_ISVR, rd);
    check_value("nest ISVR", 32'h0000_0208, rd);
    bus_write(ADDR_EOI, 32'd0);
    bus_read(ADDR_CISV, rd);
    check_value("nest CISV after EOI", 32'd9, rd);
    bus_write(ADDR_EOI, 32'd0);
    bus_read(ADDR_CISV, rd);
    check_value("nest CISV void", 32'd16, rd);
    drive_lines(16'h0000);
    setup_line(4'd9, 1'b0, 1'b0, 1'b0);
    setup_line(4'd3, 1'b0, 1'b0, 1'b0);
    wait_lines();
endtask

task automatic test_random();
    logic [31:0] rd;
    logic [15:0] en;
    logic [15:0] drv;
    en = 16'($urandom);
    for (int i = 0; i < 16; i++) begin
        setup_line(4'(i), en[i], 1'b0, 1'b0);
    end
    for (int r = 0; r < 20; r++) begin
        // Subset of the enabled lines
        drv = 16'($urandom) & en;
        drive_lines(drv);
        wait_lines();
        bus_write(ADDR_SOI, 32'd0);
        bus_read(ADDR_CISV, rd);
        check_value($sformatf("random round %0d CISV", r), 32'(lowest_line(drv)), rd);
        bus_write(ADDR_EOI, 32'd0);
        drive_lines(16'h0000);
        wait_lines();
    end
endtask

`endif

/* dv/tb_ipic.sv */
// Testbench for the IPIC with clock, reset, bus tasks, watchdog and the test sequence
`timescale 1ns/1ps

module tb_ipic;

    import ipic_pkg::*;

    localparam int N_TESTS  = 5;
    localparam int CLK_HALF = 2;
    // Run limit in ns as 200 cycles of 4 ns per test
    localparam int RUN_LIMIT = N_TESTS * 200 * 4;

    logic        clk;
    logic        rst_n;
    logic [15:0] irq_lines;
    logic        r_req;
    logic        w_req;
    logic [2:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        irq_m_req;

    // Error bookkeeping
    int err_cnt;
    int err_mark;
    int fail_tests;

    ipic_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines),
        .r_req_i     (r_req),
        .w_req_i     (w_req),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .rdata_o     (rdata),
        .irq_m_req_o (irq_m_req)
    );

    always #CLK_HALF clk = ~clk;

    // ------------------------------
    // Bus and line tasks
    // ------------------------------
    // Write lands at the second edge
    task automatic bus_write(input logic [2:0] a, input logic [31:0] d);
        @(posedge clk);
        w_req <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        w_req <= 1'b0;
    endtask

    // Read data sampled mid-cycle
    task automatic bus_read(input logic [2:0] a, output logic [31:0] d);
        @(posedge clk);
        r_req <= 1'b1;
        addr  <= a;
        @(negedge clk);
        d = rdata;
        @(posedge clk);
        r_req <= 1'b0;
    endtask

    task automatic drive_lines(input logic [15:0] v);
        @(posedge clk);
        irq_lines <= v;
    endtask

    // Three edges to the IPR plus one spare
    task automatic wait_lines();
        repeat (4) @(posedge clk);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
        else begin
            $display("ERR at %0t: %s expected 0x%08h got 0x%08h", $time, what, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_req(input string what, input logic exp);
        @(negedge clk);
        check_value(what, {31'd0, exp}, {31'd0, irq_m_req});
    endtask

    // One summary line per test
    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, err_cnt - err_mark);
            fail_tests++;
        end
        err_mark = err_cnt;
    endtask

    `include "tb_ipic_tests.svh"

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        #(RUN_LIMIT);
        $display("Timeout: the tests did not finish within %0d ns", RUN_LIMIT);
        $display("Regression failed");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        irq_lines  = '0;
        r_req      = 1'b0;
        w_req      = 1'b0;
        addr       = '0;
        wdata      = '0;
        err_cnt    = 0;
        err_mark   = 0;
        fail_tests = 0;
        void'($urandom(83));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        end_test("reset");
        test_level();
        end_test("level");
        test_edge();
        end_test("edge");
        test_nesting();
        end_test("nesting");
        test_random();
        end_test("random");

        $display("Summary: %0d tests, %0d failed, %0d errors", N_TESTS, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* rtl/ipic_cfg_if.sv */
// Configuration and command strobes from the IPIC register block to the interrupt logic
`timescale 1ns/1ps

interface ipic_cfg_if;

    // Per-line configuration registers
    ipic_pkg::irq_vec_t ier;
    // Mode per line, 1 = edge, 0 = level
    ipic_pkg::irq_vec_t imr;
    ipic_pkg::irq_vec_t iinvr;

    // One-cycle pending clear vector
    ipic_pkg::irq_vec_t ipr_clr_req;

    // One-cycle command strobes
    logic soi_wr;
    logic eoi_wr;

    // Register block side
    modport cfg_src (
        output ier, imr, iinvr,
        output ipr_clr_req,
        output soi_wr, eoi_wr
    );

    // Pending and service side
    modport cfg_dst (
        input ier, imr, iinvr,
        input ipr_clr_req,
        input soi_wr, eoi_wr
    );

endinterface

/* rtl/ipic_line_detect.sv */
// Two-flop synchronizer for the IPIC lines with per-line inversion and edge detection
`timescale 1ns/1ps

module ipic_line_detect (
    input  logic               clk,
    input  logic               rst_n,
    input  ipic_pkg::irq_vec_t irq_lines_i,
    input  ipic_pkg::irq_vec_t iinvr_i,
    output ipic_pkg::irq_vec_t irq_lvl_o,
    output ipic_pkg::irq_vec_t irq_edge_o
);

    import ipic_pkg::*;

    // Synchronizer stages
    irq_vec_t sync_q1;
    irq_vec_t sync_q2;
    // Previous synchronized value
    irq_vec_t lines_dly_q;

    // ------------------------------
    // Synchronizer and delay stage
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1     <= '0;
            sync_q2     <= '0;
            lines_dly_q <= '0;
        end else begin
            sync_q1     <= irq_lines_i;
            sync_q2     <= sync_q1;
            lines_dly_q <= sync_q2;
        end
    end

    // ------------------------------
    // Level and edge
    // ------------------------------
    // Active level after inversion
    assign irq_lvl_o  = sync_q2 ^ iinvr_i;

    // Any change, kept only when the new level is active
    assign irq_edge_o = (sync_q2 ^ lines_dly_q) & irq_lvl_o;

endmodule

/* rtl/ipic_pending.sv */
// Interrupt pending register of the IPIC with level, edge and clear rules
`timescale 1ns/1ps

module ipic_pending (
    input  logic                 clk,
    input  logic                 rst_n,
    ipic_cfg_if.cfg_dst          cfg,
    input  ipic_pkg::irq_vec_t   irq_lvl_i,
    input  ipic_pkg::irq_vec_t   irq_edge_i,
    input  logic                 start_i,
    input  ipic_pkg::irq_idx_t   start_idx_i,
    output ipic_pkg::irq_vec_t   ipr_o
);

    import ipic_pkg::*;

    irq_vec_t ipr_q;
    irq_vec_t ipr_next;
    // Bits asked to clear this cycle
    irq_vec_t clr_req;
    // Bits allowed to clear
    irq_vec_t clr_cond;

    // ------------------------------
    // Clear request
    // ------------------------------
    // Register writes plus the line being started by SOI
    always_comb begin
        clr_req = cfg.ipr_clr_req;
        if (start_i) begin
            clr_req[start_idx_i] = 1'b1;
        end
    end

    // Active level lines hold in level mode
    assign clr_cond = ~irq_lvl_i | cfg.imr;

    // ------------------------------
    // Next state per line
    // ------------------------------
    always_comb begin
        for (int i = 0; i < IRQ_NUM; i++) begin
            if (clr_req[i] && clr_cond[i]) begin
                ipr_next[i] = 1'b0;
            end else if (!cfg.imr[i]) begin
                // Level mode follows the line
                ipr_next[i] = irq_lvl_i[i];
            end else begin
                // Edge mode is sticky
                ipr_next[i] = ipr_q[i] | irq_edge_i[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ipr_q <= '0;
        end else begin
            ipr_q <= ipr_next;
        end
    end

    assign ipr_o = ipr_q;

endmodule

/* rtl/ipic_pkg.sv */
// Shared sizes, types, register map and ICSR layout for the 16-line interrupt controller
package ipic_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int IRQ_NUM   = 16;
    localparam int IRQ_IDX_W = 4;
    // One extra bit so the void vector fits
    localparam int VECT_W    = IRQ_IDX_W + 1;
    localparam int XLEN      = 32;

    // Per-line bit vector and line index
    typedef logic [IRQ_NUM-1:0]   irq_vec_t;
    typedef logic [IRQ_IDX_W-1:0] irq_idx_t;
    // Vector number, top bit set means void
    typedef logic [VECT_W-1:0]    vect_t;

    // Nothing in service
    localparam vect_t VOID_VECT = vect_t'(16);

    // ------------------------------
    // Register address map
    // ------------------------------
    typedef enum logic [2:0] {
        ADDR_CISV = 3'd0,
        ADDR_RSVD = 3'd1,
        ADDR_IPR  = 3'd2,
        ADDR_ISVR = 3'd3,
        ADDR_EOI  = 3'd4,
        ADDR_SOI  = 3'd5,
        ADDR_IDX  = 3'd6,
        ADDR_ICSR = 3'd7
    } ipic_addr_e;

    // ------------------------------
    // ICSR bit positions
    // ------------------------------
    localparam int ICSR_IP      = 0;
    localparam int ICSR_IE      = 1;
    localparam int ICSR_IM      = 2;
    localparam int ICSR_INV     = 3;
    localparam int ICSR_IS      = 4;
    // Privilege field, fixed to machine mode
    localparam int ICSR_PRV_LSB = 8;
    localparam int PRV_W        = 2;
    localparam logic [PRV_W-1:0] PRV_M = 2'd3;
    // Line number field
    localparam int ICSR_LN_LSB  = 16;

endpackage

/* rtl/ipic_regs.sv */
// Register block of the IPIC with address decode, read mux and per-line configuration
`timescale 1ns/1ps

module ipic_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          r_req_i,
    input  logic                          w_req_i,
    input  ipic_pkg::ipic_addr_e          addr_i,
    input  logic [ipic_pkg::XLEN-1:0]     wdata_i,
    output logic [ipic_pkg::XLEN-1:0]     rdata_o,
    ipic_cfg_if.cfg_src                   cfg,
    input  ipic_pkg::irq_vec_t            ipr_i,
    input  ipic_pkg::irq_vec_t            isvr_i,
    input  ipic_pkg::vect_t               cisv_i
);

    import ipic_pkg::*;

    // Write strobes
    logic idx_wr;
    logic icsr_wr;
    logic ipr_wr;

    // Index register and per-line configuration
    irq_idx_t idx_q;
    irq_vec_t ier_q;
    irq_vec_t imr_q;
    irq_vec_t iinvr_q;

    // ------------------------------
    // Write decode
    // ------------------------------
    always_comb begin
        idx_wr     = 1'b0;
        icsr_wr    = 1'b0;
        ipr_wr     = 1'b0;
        cfg.soi_wr = 1'b0;
        cfg.eoi_wr = 1'b0;
        if (w_req_i) begin
            case (addr_i)
                ADDR_IDX:  idx_wr     = 1'b1;
                ADDR_ICSR: icsr_wr    = 1'b1;
                ADDR_IPR:  ipr_wr     = 1'b1;
                ADDR_SOI:  cfg.soi_wr = 1'b1;
                ADDR_EOI:  cfg.eoi_wr = 1'b1;
                // CISV and ISVR are read-only and reserved is ignored
                default: begin
                end
            endcase
        end
    end

    // IPR write is one-to-clear and ICSR clears only the indexed line
    always_comb begin
        cfg.ipr_clr_req = '0;
        if (ipr_wr) begin
            cfg.ipr_clr_req = wdata_i[IRQ_NUM-1:0];
        end else if (icsr_wr) begin
            cfg.ipr_clr_req[idx_q] = wdata_i[ICSR_IP];
        end
    end

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (idx_wr) begin
            idx_q <= wdata_i[IRQ_IDX_W-1:0];
        end
    end

    // Configuration bits of the line at IDX
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ier_q   <= '0;
            imr_q   <= '0;
            iinvr_q <= '0;
        end else if (icsr_wr) begin
            ier_q[idx_q]   <= wdata_i[ICSR_IE];
            imr_q[idx_q]   <= wdata_i[ICSR_IM];
            iinvr_q[idx_q] <= wdata_i[ICSR_INV];
        end
    end

    assign cfg.ier   = ier_q;
    assign cfg.imr   = imr_q;
    assign cfg.iinvr = iinvr_q;

    // ------------------------------
    // Read mux
    // ------------------------------
    always_comb begin
        rdata_o = '0;
        if (r_req_i) begin
            case (addr_i)
                ADDR_CISV: rdata_o = XLEN'(cisv_i);
                ADDR_IPR:  rdata_o = XLEN'(ipr_i);
                ADDR_ISVR: rdata_o = XLEN'(isvr_i);
                ADDR_IDX:  rdata_o = XLEN'(idx_q);
                ADDR_ICSR: begin
                    rdata_o[ICSR_IP]  = ipr_i[idx_q];
                    rdata_o[ICSR_IE]  = ier_q[idx_q];
                    rdata_o[ICSR_IM]  = imr_q[idx_q];
                    rdata_o[ICSR_INV] = iinvr_q[idx_q];
                    rdata_o[ICSR_IS]  = isvr_i[idx_q];
                    rdata_o[ICSR_PRV_LSB +: PRV_W]    = PRV_M;
                    rdata_o[ICSR_LN_LSB +: IRQ_IDX_W] = idx_q;
                end
                // Command and reserved addresses read zero
                default: rdata_o = '0;
            endcase
        end
    end

    // Single access per cycle on the bus
    a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(r_req_i && w_req_i));

endmodule

/* rtl/ipic_service.sv */
// Priority selection, in-service tracking and the machine interrupt request of the IPIC
`timescale 1ns/1ps

module ipic_service (
    input  logic                 clk,
    input  logic                 rst_n,
    ipic_cfg_if.cfg_dst          cfg,
    input  ipic_pkg::irq_vec_t   ipr_i,
    output ipic_pkg::irq_vec_t   isvr_o,
    output ipic_pkg::vect_t      cisv_o,
    output logic                 start_o,
    output ipic_pkg::irq_idx_t   start_idx_o,
    output logic                 irq_m_req_o
);

    import ipic_pkg::*;

    // Lowest set index wins, void when empty
    function automatic vect_t find_lowest(input irq_vec_t v);
        vect_t res;
        res = VOID_VECT;
        for (int i = IRQ_NUM - 1; i >= 0; i--) begin
            if (v[i]) begin
                res = vect_t'(i);
            end
        end
        return res;
    endfunction

    irq_vec_t isvr_q;
    vect_t    cisv_q;

    // Pending and enabled lines
    irq_vec_t req_v;
    vect_t    req_vect;
    logic     req_vd;
    irq_idx_t req_idx;

    // Current vector in service
    logic     serv_vd;
    irq_idx_t serv_idx;

    // ISVR without the current bit, used on EOI
    irq_vec_t isvr_rest;
    vect_t    resume_vect;
    logic     eoi_act;

    // ------------------------------
    // Selection
    // ------------------------------
    assign req_v    = ipr_i & cfg.ier;
    assign req_vect = find_lowest(req_v);
    assign req_vd   = ~req_vect[VECT_W-1];
    assign req_idx  = req_vect[IRQ_IDX_W-1:0];

    assign serv_vd  = ~cisv_q[VECT_W-1];
    assign serv_idx = cisv_q[IRQ_IDX_W-1:0];

    always_comb begin
        isvr_rest = isvr_q;
        if (serv_vd) begin
            isvr_rest[serv_idx] = 1'b0;
        end
    end

    assign resume_vect = find_lowest(isvr_rest);

    // Preempt only with a strictly higher priority line
    assign irq_m_req_o = req_vd & (~serv_vd | (req_idx < serv_idx));

    // SOI only takes effect with a request up
    assign start_o     = cfg.soi_wr & irq_m_req_o;
    assign start_idx_o = req_idx;
    assign eoi_act     = cfg.eoi_wr & serv_vd;

    // ------------------------------
    // ISVR and CISV
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr_q <= '0;
            cisv_q <= VOID_VECT;
        end else if (start_o) begin
            isvr_q[req_idx] <= 1'b1;
            cisv_q          <= req_vect;
        end else if (eoi_act) begin
            isvr_q <= isvr_rest;
            cisv_q <= resume_vect;
        end
    end

    assign isvr_o = isvr_q;
    assign cisv_o = cisv_q;

    // ------------------------------
    // Checks
    // ------------------------------
    // Started line must be pending in the IPR and enabled
    a_start_pending: assert property (@(posedge clk) disable iff (!rst_n)
        start_o |-> (ipr_i[start_idx_o] && cfg.ier[start_idx_o]));

    // CISV holds a real line or the void vector
    a_cisv_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (cisv_q < IRQ_NUM) || (cisv_q == VOID_VECT));

endmodule

/* rtl/ipic_top.sv */
// Top level of the 16-line programmable interrupt controller
`timescale 1ns/1ps

module ipic_top (
    input  logic                      clk,
    input  logic                      rst_n,

    // Asynchronous interrupt lines
    input  ipic_pkg::irq_vec_t        irq_lines_i,

    // Register port, single-cycle strobes
    input  logic                      r_req_i,
    input  logic                      w_req_i,
    input  logic [2:0]                addr_i,
    input  logic [ipic_pkg::XLEN-1:0] wdata_i,
    output logic [ipic_pkg::XLEN-1:0] rdata_o,

    // Machine interrupt request
    output logic                      irq_m_req_o
);

    import ipic_pkg::*;

    ipic_addr_e addr;

    // Line detection to pending
    irq_vec_t irq_lvl;
    irq_vec_t irq_edge;

    // Status back to the register block
    irq_vec_t ipr;
    irq_vec_t isvr;
    vect_t    cisv;

    // SOI hand-off to pending
    logic     start;
    irq_idx_t start_idx;

    assign addr = ipic_addr_e'(addr_i);

    ipic_cfg_if cfg_if ();

    // ------------------------------
    // Instances
    // ------------------------------
    ipic_line_detect u_line_detect (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines_i),
        .iinvr_i     (cfg_if.iinvr),
        .irq_lvl_o   (irq_lvl),
        .irq_edge_o  (irq_edge)
    );

    ipic_pending u_pending (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg_if.cfg_dst),
        .irq_lvl_i   (irq_lvl),
        .irq_edge_i  (irq_edge),
        .start_i     (start),
        .start_idx_i (start_idx),
        .ipr_o       (ipr)
    );

    ipic_service u_service (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg_if.cfg_dst),
        .ipr_i       (ipr),
        .isvr_o      (isvr),
        .cisv_o      (cisv),
        .start_o     (start),
        .start_idx_o (start_idx),
        .irq_m_req_o (irq_m_req_o)
    );

    ipic_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .r_req_i (r_req_i),
        .w_req_i (w_req_i),
        .addr_i  (addr),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .cfg     (cfg_if.cfg_src),
        .ipr_i   (ipr),
        .isvr_i  (isvr),
        .cisv_i  (cisv)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the IPIC testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_ipic -Mdir obj_dir -o tb_ipic_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ipic_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
exit 1
